// File: rtl/opl_consts.svh
`ifndef OPL_CONSTS_SVH
`define OPL_CONSTS_SVH

// Stream widths
`define OPL_DATA_WIDTH        512
`define OPL_TUSER_WIDTH       128

// One-hot port bytes in tuser, lowest bit
`define OPL_SRC_PORT_POS      16
`define OPL_DST_PORT_POS      24

// Head beat field positions
`define OPL_IP_PROTO_POS      184
`define OPL_IP_DST_POS        240
`define OPL_PROTO_ICMP        8'h01

`define OPL_FIFO_DEPTH_BITS   2       // 4 entries

// Register map
`define OPL_REG_ID            12'h000
`define OPL_REG_VERSION       12'h004
`define OPL_REG_RESET         12'h008
`define OPL_REG_PKTIN         12'h00C
`define OPL_REG_PKTOUT        12'h010
`define OPL_REG_ICMPOUT       12'h014
`define OPL_REG_TGTIP         12'h018
`define OPL_REG_TGTIPOUT      12'h01C

`define OPL_ID_VALUE          32'h0000_DA01
`define OPL_VERSION_VALUE     32'h0001_0000
`define OPL_RST_CLR_CNT_BIT   0       // Clear counters
`define OPL_RST_CLR_REGS_BIT  4       // Clear counters and target IP

`endif

// File: rtl/opl_pkg.sv
`include "opl_consts.svh"

package opl_pkg;

  // Plain vectors
  typedef logic [`OPL_DATA_WIDTH-1:0]     data_t;
  typedef logic [`OPL_DATA_WIDTH/8-1:0]   keep_t;   // One bit per data byte
  typedef logic [`OPL_TUSER_WIDTH-1:0]    tuser_t;
  typedef logic [7:0]                     port_map_t;
  typedef logic [7:0]                     ip_proto_t;
  typedef logic [31:0]                    ipv4_addr_t;
  typedef logic [31:0]                    stat_cnt_t;  // [31] sticky overflow, [30:0] count
  typedef logic [11:0]                    apb_addr_t;
  typedef logic [31:0]                    apb_data_t;

  // One stream beat, also one FIFO entry
  typedef struct packed {
    logic   tlast;
    tuser_t tuser;
    keep_t  tkeep;
    data_t  tdata;
  } axis_beat_t;

  typedef struct packed {
    logic is_icmp;
    logic is_tgtip;
  } pkt_class_t;

  // Single-cycle strobes
  typedef struct packed {
    logic in_end;
    logic out_begin;
    logic out_end;
  } pkt_events_t;

  typedef struct packed {
    logic all;
    logic pktin;
    logic pktout;
    logic icmpout;
    logic tgtipout;
  } stat_clear_t;

  typedef struct packed {
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
  } apb_req_t;

  typedef struct packed {
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
  } apb_rsp_t;

  typedef enum logic {
    st_header = 1'b0,
    st_body   = 1'b1
  } opl_state_e;

endpackage

// File: rtl/opl_pkt_fifo.sv
`include "opl_consts.svh"

module opl_pkt_fifo (
  input  logic                axis_aclk,
  input  logic                axis_resetn,
  input  opl_pkg::axis_beat_t wr_beat,
  input  logic                wr_en,
  input  logic                rd_en,
  output opl_pkg::axis_beat_t head,
  output logic                empty,
  output logic                nearly_full
);

  localparam int depth_bits = `OPL_FIFO_DEPTH_BITS;
  localparam int depth      = 1 << depth_bits;

  opl_pkg::axis_beat_t    mem [depth];  // Beat storage, no reset
  logic [depth_bits-1:0]  wr_ptr;
  logic [depth_bits-1:0]  rd_ptr;
  logic [depth_bits:0]    count;        // One extra bit to hold "full"
  logic                   do_wr;
  logic                   do_rd;

  assign do_rd = rd_en && (count != '0);   // Never pop an empty buffer
  assign do_wr = wr_en && (count != (depth_bits + 1)'(depth));

  // Fall-through head, no read latency
  assign head        = mem[rd_ptr];
  assign empty       = (count == '0);
  assign nearly_full = (count >= (depth_bits + 1)'(depth - 1));  // Room for one beat in flight

  always_ff @(posedge axis_aclk) begin
    if (do_wr) mem[wr_ptr] <= wr_beat;
  end

  always_ff @(posedge axis_aclk) begin
    if (!axis_resetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) wr_ptr <= wr_ptr + 1'b1;  // Wraps at depth
      if (do_rd) rd_ptr <= rd_ptr + 1'b1;
      // Occupancy
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;           // Both or neither
      endcase
    end
  end

endmodule

// File: rtl/opl_header_decode.sv
`include "opl_consts.svh"

module opl_header_decode (
  input  opl_pkg::axis_beat_t head,
  input  opl_pkg::ipv4_addr_t tgt_ip,
  output opl_pkg::pkt_class_t pkt_class
);

  opl_pkg::ip_proto_t  ip_proto;
  opl_pkg::ipv4_addr_t ip_dst;

  // Fields straight off the head beat
  assign ip_proto = head.tdata[`OPL_IP_PROTO_POS +: $bits(opl_pkg::ip_proto_t)];
  assign ip_dst   = head.tdata[`OPL_IP_DST_POS +: $bits(opl_pkg::ipv4_addr_t)];

  // Only meaningful on a first beat, qualified downstream
  assign pkt_class.is_icmp  = (ip_proto == `OPL_PROTO_ICMP);
  assign pkt_class.is_tgtip = (ip_dst == tgt_ip);   // Exact match

endmodule

// File: rtl/opl_port_select.sv
`include "opl_consts.svh"

module opl_port_select (
  input  logic                 axis_aclk,
  input  logic                 axis_resetn,
  input  opl_pkg::axis_beat_t  head,
  input  logic                 empty,
  input  logic                 m_ready,
  input  logic                 s_accept_last,
  output opl_pkg::tuser_t      tuser,
  output logic                 pop,
  output opl_pkg::pkt_events_t events
);

  opl_pkg::opl_state_e state;
  opl_pkg::opl_state_e state_next;
  opl_pkg::port_map_t  src_port;
  opl_pkg::port_map_t  dst_port;
  logic                from_cpu;

  assign pop = m_ready && !empty;  // Head leaves this cycle

  // Lookup from the source byte
  assign src_port = head.tuser[`OPL_SRC_PORT_POS +: 8];
  assign from_cpu = |(src_port & 8'hAA);  // CPU ports sit on odd bits

  always_comb begin
    if (src_port == '0)
      dst_port = 8'h01;            // Unknown source goes to MAC 0
    else if (from_cpu)
      dst_port = src_port >> 1;    // CPU to its MAC
    else
      dst_port = src_port << 1;    // MAC to its CPU port
  end

  // Only the first beat carries the rewritten destination
  always_comb begin
    tuser = head.tuser;
    if (state == opl_pkg::st_header)
      tuser[`OPL_DST_PORT_POS +: 8] = dst_port;
  end

  always_comb begin
    state_next = state;
    if (pop) begin
      if (head.tlast)
        state_next = opl_pkg::st_header;   // Single or last beat
      else if (state == opl_pkg::st_header)
        state_next = opl_pkg::st_body;
    end
  end

  always_ff @(posedge axis_aclk) begin
    if (!axis_resetn) state <= opl_pkg::st_header;
    else              state <= state_next;
  end

  // Counted once per accepted beat, never while stalled
  assign events.in_end    = s_accept_last;
  assign events.out_begin = pop && (state == opl_pkg::st_header);
  assign events.out_end   = pop && head.tlast;

endmodule

// File: rtl/opl_stats_counters.sv
module opl_stats_counters (
  input  logic                 axis_aclk,
  input  logic                 axis_resetn,
  input  opl_pkg::pkt_events_t events,
  input  opl_pkg::pkt_class_t  pkt_class,
  input  opl_pkg::stat_clear_t clear,
  output opl_pkg::stat_cnt_t   pktin,
  output opl_pkg::stat_cnt_t   pktout,
  output opl_pkg::stat_cnt_t   icmpout,
  output opl_pkg::stat_cnt_t   tgtipout
);

  logic inc_icmp;
  logic inc_tgtip;

  // Next value of one counter word, clear beats increment
  function automatic opl_pkg::stat_cnt_t cnt_next(
    input opl_pkg::stat_cnt_t cur,
    input logic               inc,
    input logic               clr
  );
    logic [31:0] sum;
    sum = {1'b0, cur[30:0]} + 32'(inc);  // Bit 31 of sum is the wrap
    if (clr)
      return '0;
    return {cur[31] | sum[31], sum[30:0]};   // Overflow stays set
  endfunction

  // Class only counts on the first popped beat
  assign inc_icmp  = events.out_begin && pkt_class.is_icmp;
  assign inc_tgtip = events.out_begin && pkt_class.is_tgtip;

  always_ff @(posedge axis_aclk) begin
    if (!axis_resetn) begin
      pktin    <= '0;
      pktout   <= '0;
      icmpout  <= '0;
      tgtipout <= '0;
    end else begin
      pktin    <= cnt_next(pktin, events.in_end, clear.all || clear.pktin);
      pktout   <= cnt_next(pktout, events.out_end, clear.all || clear.pktout);
      icmpout  <= cnt_next(icmpout, inc_icmp, clear.all || clear.icmpout);
      tgtipout <= cnt_next(tgtipout, inc_tgtip, clear.all || clear.tgtipout);
    end
  end

endmodule

// File: rtl/opl_apb_regs.sv
`include "opl_consts.svh"

module opl_apb_regs (
  input  logic                 axis_aclk,
  input  logic                 axis_resetn,
  input  opl_pkg::apb_req_t    apb_req,
  output opl_pkg::apb_rsp_t    apb_rsp,
  input  opl_pkg::stat_cnt_t   pktin,
  input  opl_pkg::stat_cnt_t   pktout,
  input  opl_pkg::stat_cnt_t   icmpout,
  input  opl_pkg::stat_cnt_t   tgtipout,
  output opl_pkg::ipv4_addr_t  tgt_ip,
  output opl_pkg::stat_clear_t clear
);

  // Only the two defined reset bits are kept
  localparam opl_pkg::apb_data_t rst_mask =
    (32'd1 << `OPL_RST_CLR_CNT_BIT) | (32'd1 << `OPL_RST_CLR_REGS_BIT);

  logic               access;
  logic               wr_access;
  logic               rd_access;
  logic               mapped;
  logic               writable;
  opl_pkg::apb_data_t rd_data;
  opl_pkg::apb_data_t rst_pulse;   // Lives for one cycle after a write

  assign access    = apb_req.psel && apb_req.penable;   // Access phase
  assign wr_access = access && apb_req.pwrite;
  assign rd_access = access && !apb_req.pwrite;

  // Offset decode and read mux
  always_comb begin
    mapped   = 1'b1;
    writable = 1'b0;
    rd_data  = '0;
    case (apb_req.paddr)
      `OPL_REG_ID:       rd_data = `OPL_ID_VALUE;
      `OPL_REG_VERSION:  rd_data = `OPL_VERSION_VALUE;
      `OPL_REG_RESET: begin
        rd_data  = rst_pulse;
        writable = 1'b1;
      end
      `OPL_REG_PKTIN:    rd_data = pktin;
      `OPL_REG_PKTOUT:   rd_data = pktout;
      `OPL_REG_ICMPOUT:  rd_data = icmpout;
      `OPL_REG_TGTIP: begin
        rd_data  = tgt_ip;
        writable = 1'b1;
      end
      `OPL_REG_TGTIPOUT: rd_data = tgtipout;
      default:           mapped  = 1'b0;   // Hole in the map
    endcase
  end

  assign apb_rsp.prdata  = rd_data;
  assign apb_rsp.pready  = access;          // Zero wait states
  assign apb_rsp.pslverr = access && (!mapped || (apb_req.pwrite && !writable));

  // Self-clearing reset register
  always_ff @(posedge axis_aclk) begin
    if (!axis_resetn)
      rst_pulse <= '0;
    else if (wr_access && (apb_req.paddr == `OPL_REG_RESET))
      rst_pulse <= apb_req.pwdata & rst_mask;
    else
      rst_pulse <= '0;
  end

  always_ff @(posedge axis_aclk) begin
    if (!axis_resetn)
      tgt_ip <= '0;
    else if (rst_pulse[`OPL_RST_CLR_REGS_BIT])
      tgt_ip <= '0;                           // Register reset
    else if (wr_access && (apb_req.paddr == `OPL_REG_TGTIP))
      tgt_ip <= apb_req.pwdata;
  end

  // Either reset bit wipes all counters
  assign clear.all      = rst_pulse[`OPL_RST_CLR_CNT_BIT] || rst_pulse[`OPL_RST_CLR_REGS_BIT];
  // Clear on read, same edge as the access
  assign clear.pktin    = rd_access && (apb_req.paddr == `OPL_REG_PKTIN);
  assign clear.pktout   = rd_access && (apb_req.paddr == `OPL_REG_PKTOUT);
  assign clear.icmpout  = rd_access && (apb_req.paddr == `OPL_REG_ICMPOUT);
  assign clear.tgtipout = rd_access && (apb_req.paddr == `OPL_REG_TGTIPOUT);

endmodule

// File: rtl/nic_output_port_lookup.sv
module nic_output_port_lookup (
  input  logic                axis_aclk,
  input  logic                axis_resetn,

  input  opl_pkg::data_t      s_axis_tdata,
  input  opl_pkg::keep_t      s_axis_tkeep,
  input  opl_pkg::tuser_t     s_axis_tuser,
  input  logic                s_axis_tvalid,
  input  logic                s_axis_tlast,
  output logic                s_axis_tready,

  output opl_pkg::data_t      m_axis_tdata,
  output opl_pkg::keep_t      m_axis_tkeep,
  output opl_pkg::tuser_t     m_axis_tuser,
  output logic                m_axis_tvalid,
  output logic                m_axis_tlast,
  input  logic                m_axis_tready,

  input  opl_pkg::apb_req_t   apb_req,
  output opl_pkg::apb_rsp_t   apb_rsp
);

  opl_pkg::axis_beat_t  in_beat;
  opl_pkg::axis_beat_t  head;
  logic                 s_accept;
  logic                 fifo_empty;
  logic                 fifo_nearly_full;
  logic                 pop;
  opl_pkg::pkt_class_t  pkt_class;
  opl_pkg::pkt_events_t events;
  opl_pkg::stat_clear_t clear;
  opl_pkg::ipv4_addr_t  tgt_ip;
  opl_pkg::stat_cnt_t   pktin;
  opl_pkg::stat_cnt_t   pktout;
  opl_pkg::stat_cnt_t   icmpout;
  opl_pkg::stat_cnt_t   tgtipout;

  // Input beat into one FIFO word
  assign in_beat.tlast = s_axis_tlast;
  assign in_beat.tuser = s_axis_tuser;
  assign in_beat.tkeep = s_axis_tkeep;
  assign in_beat.tdata = s_axis_tdata;

  assign s_axis_tready = !fifo_nearly_full;
  assign s_accept      = s_axis_tvalid && s_axis_tready;

  // Head fields out, tuser comes rewritten
  assign m_axis_tvalid = !fifo_empty;
  assign m_axis_tdata  = head.tdata;
  assign m_axis_tkeep  = head.tkeep;
  assign m_axis_tlast  = head.tlast;

  opl_pkt_fifo u_fifo (
    .axis_aclk   (axis_aclk),
    .axis_resetn (axis_resetn),
    .wr_beat     (in_beat),
    .wr_en       (s_accept),
    .rd_en       (pop),
    .head        (head),
    .empty       (fifo_empty),
    .nearly_full (fifo_nearly_full)
  );

  opl_header_decode u_decode (
    .head      (head),
    .tgt_ip    (tgt_ip),
    .pkt_class (pkt_class)
  );

  opl_port_select u_port_select (
    .axis_aclk     (axis_aclk),
    .axis_resetn   (axis_resetn),
    .head          (head),
    .empty         (fifo_empty),
    .m_ready       (m_axis_tready),
    .s_accept_last (s_accept && s_axis_tlast),
    .tuser         (m_axis_tuser),
    .pop           (pop),
    .events        (events)
  );

  opl_stats_counters u_stats (
    .axis_aclk   (axis_aclk),
    .axis_resetn (axis_resetn),
    .events      (events),
    .pkt_class   (pkt_class),
    .clear       (clear),
    .pktin       (pktin),
    .pktout      (pktout),
    .icmpout     (icmpout),
    .tgtipout    (tgtipout)
  );

  opl_apb_regs u_regs (
    .axis_aclk   (axis_aclk),
    .axis_resetn (axis_resetn),
    .apb_req     (apb_req),
    .apb_rsp     (apb_rsp),
    .pktin       (pktin),
    .pktout      (pktout),
    .icmpout     (icmpout),
    .tgtipout    (tgtipout),
    .tgt_ip      (tgt_ip),
    .clear       (clear)
  );

endmodule

// File: testbench/tb_nic_output_port_lookup.sv
`include "opl_consts.svh"

module tb_nic_output_port_lookup;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int wait_limit = 200;   // Cycles before any wait gives up
  localparam int max_beats  = 16;

  logic                axis_aclk;
  logic                axis_resetn;
  opl_pkg::data_t      s_axis_tdata;
  opl_pkg::keep_t      s_axis_tkeep;
  opl_pkg::tuser_t     s_axis_tuser;
  logic                s_axis_tvalid;
  logic                s_axis_tlast;
  logic                s_axis_tready;
  opl_pkg::data_t      m_axis_tdata;
  opl_pkg::keep_t      m_axis_tkeep;
  opl_pkg::tuser_t     m_axis_tuser;
  logic                m_axis_tvalid;
  logic                m_axis_tlast;
  logic                m_axis_tready;
  opl_pkg::apb_req_t   apb_req;
  opl_pkg::apb_rsp_t   apb_rsp;

  // Beats to send, with the destination byte expected on first beats
  opl_pkg::axis_beat_t tx_beats [max_beats];
  logic                tx_first [max_beats];
  opl_pkg::port_map_t  tx_dst   [max_beats];
  opl_pkg::axis_beat_t rx_beats [max_beats];
  int                  rx_cnt;
  int                  test_errs;   // Errors in the running test
  int                  tests_ok;
  int                  tests_bad;

  nic_output_port_lookup UUT (
    .axis_aclk     (axis_aclk),
    .axis_resetn   (axis_resetn),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tkeep  (s_axis_tkeep),
    .s_axis_tuser  (s_axis_tuser),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tlast  (s_axis_tlast),
    .s_axis_tready (s_axis_tready),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tkeep  (m_axis_tkeep),
    .m_axis_tuser  (m_axis_tuser),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tlast  (m_axis_tlast),
    .m_axis_tready (m_axis_tready),
    .apb_req       (apb_req),
    .apb_rsp       (apb_rsp)
  );

  initial axis_aclk = 1'b0;
  always #10 axis_aclk = ~axis_aclk;   // 20 ns period

  task automatic check_value(input string name, input logic [511:0] exp,
                             input logic [511:0] act);
    if (exp !== act) begin
      $display("[FAIL] %s: expected %0h, got %0h", name, exp, act);
      test_errs++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout: gave up waiting for %s", what);
    test_errs++;
  endtask

  task automatic finish_test(input string name);
    if (test_errs == 0) begin
      tests_ok++;
      $display("done %s: all checks matched", name);
    end else begin
      tests_bad++;
      $display("done %s: %0d errors", name, test_errs);
    end
    test_errs = 0;
  endtask

  // One APB transfer with its setup and access cycles
  task automatic apb_access(input logic write, input opl_pkg::apb_addr_t addr,
                            input opl_pkg::apb_data_t wdata,
                            output opl_pkg::apb_data_t rdata, output logic err);
    @(posedge axis_aclk);
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= write;
    apb_req.paddr   <= addr;
    apb_req.pwdata  <= wdata;
    @(posedge axis_aclk);
    apb_req.penable <= 1'b1;
    @(negedge axis_aclk);
    check_value("pready", 1, apb_rsp.pready);   // Zero wait states
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    @(posedge axis_aclk);   // Access edge
    apb_req.psel    <= 1'b0;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= 1'b0;
  endtask

  task automatic apb_write(input opl_pkg::apb_addr_t addr, input opl_pkg::apb_data_t data);
    opl_pkg::apb_data_t rdata;
    logic               err;
    apb_access(1'b1, addr, data, rdata, err);
    check_value("pslverr", 0, err);
  endtask

  task automatic apb_read_check(input opl_pkg::apb_addr_t addr, input string name,
                                input opl_pkg::apb_data_t exp);
    opl_pkg::apb_data_t rdata;
    logic               err;
    apb_access(1'b0, addr, '0, rdata, err);
    check_value(name, exp, rdata);
    check_value("pslverr", 0, err);
  endtask

  // Reads wipe the counters
  task automatic clear_counters();
    opl_pkg::apb_data_t rdata;
    logic               err;
    apb_access(1'b0, `OPL_REG_PKTIN, '0, rdata, err);
    apb_access(1'b0, `OPL_REG_PKTOUT, '0, rdata, err);
    apb_access(1'b0, `OPL_REG_ICMPOUT, '0, rdata, err);
    apb_access(1'b0, `OPL_REG_TGTIPOUT, '0, rdata, err);
  endtask

  task automatic make_packet(input int base, input int nbeats, input opl_pkg::ip_proto_t proto,
                             input opl_pkg::ipv4_addr_t dst_ip, input opl_pkg::port_map_t src,
                             input opl_pkg::port_map_t exp_dst);
    opl_pkg::axis_beat_t beat;
    int                  b;
    int                  w;
    for (b = 0; b < nbeats; b++) begin
      for (w = 0; w < 16; w++)
        beat.tdata[w*32 +: 32] = $urandom;
      for (w = 0; w < 4; w++)
        beat.tuser[w*32 +: 32] = $urandom;   // Stale dst byte must be overwritten
      beat.tlast = (b == nbeats - 1);
      beat.tkeep = beat.tlast ? {$urandom, $urandom} : '1;
      if (b == 0) begin
        beat.tdata[`OPL_IP_PROTO_POS +: 8] = proto;
        beat.tdata[`OPL_IP_DST_POS +: 32]  = dst_ip;
        beat.tuser[`OPL_SRC_PORT_POS +: 8] = src;
      end
      tx_beats[base + b] = beat;
      tx_first[base + b] = (b == 0);
      tx_dst[base + b]   = exp_dst;
    end
  endtask

  task automatic send_beats(input int n);
    int i;
    int waited;
    @(posedge axis_aclk);
    for (i = 0; i < n; i++) begin
      s_axis_tvalid <= 1'b1;
      s_axis_tdata  <= tx_beats[i].tdata;
      s_axis_tkeep  <= tx_beats[i].tkeep;
      s_axis_tuser  <= tx_beats[i].tuser;
      s_axis_tlast  <= tx_beats[i].tlast;
      waited = 0;
      @(negedge axis_aclk);
      while (!s_axis_tready && waited < wait_limit) begin
        @(negedge axis_aclk);
        waited++;
      end
      if (!s_axis_tready)
        report_timeout("s_axis_tready");
      @(posedge axis_aclk);   // Beat accepted here
    end
    s_axis_tvalid <= 1'b0;
    s_axis_tlast  <= 1'b0;
  endtask

  task automatic collect_beats(input int n);
    int waited;
    waited = 0;
    rx_cnt = 0;
    @(posedge axis_aclk);
    m_axis_tready <= 1'b1;
    while (rx_cnt < n && waited < wait_limit) begin
      @(negedge axis_aclk);
      if (m_axis_tvalid) begin   // Popped at the coming edge
        rx_beats[rx_cnt] = {m_axis_tlast, m_axis_tuser, m_axis_tkeep, m_axis_tdata};
        rx_cnt++;
      end
      waited++;
    end
    if (rx_cnt < n)
      report_timeout("output beats");
    @(posedge axis_aclk);
    m_axis_tready <= 1'b0;
  endtask

  // Output must equal input, except the dst byte of first beats
  task automatic compare_rx(input int n);
    opl_pkg::axis_beat_t exp;
    int                  i;
    for (i = 0; i < n && i < rx_cnt; i++) begin
      exp = tx_beats[i];
      if (tx_first[i])
        exp.tuser[`OPL_DST_PORT_POS +: 8] = tx_dst[i];
      check_value("m_axis_tdata", exp.tdata, rx_beats[i].tdata);
      check_value("m_axis_tkeep", exp.tkeep, rx_beats[i].tkeep);
      check_value("m_axis_tuser", exp.tuser, rx_beats[i].tuser);
      check_value("m_axis_tlast", exp.tlast, rx_beats[i].tlast);
    end
  endtask

  task automatic test_reset_state();
    opl_pkg::apb_data_t rdata;
    logic               err;
    apb_read_check(`OPL_REG_ID, "id", `OPL_ID_VALUE);
    apb_read_check(`OPL_REG_VERSION, "version", `OPL_VERSION_VALUE);
    apb_read_check(`OPL_REG_PKTIN, "pktin", 0);
    apb_read_check(`OPL_REG_PKTOUT, "pktout", 0);
    apb_read_check(`OPL_REG_ICMPOUT, "icmpout", 0);
    apb_read_check(`OPL_REG_TGTIPOUT, "tgtipout", 0);
    @(negedge axis_aclk);
    check_value("m_axis_tvalid", 0, m_axis_tvalid);
    check_value("s_axis_tready", 1, s_axis_tready);
    apb_access(1'b0, 12'h040, '0, rdata, err);   // Hole in the map
    check_value("pslverr", 1, err);
    apb_access(1'b1, `OPL_REG_ID, 32'h1234_5678, rdata, err);   // Read-only
    check_value("pslverr", 1, err);
    apb_read_check(`OPL_REG_ID, "id", `OPL_ID_VALUE);
    finish_test("reset state");
  endtask

  task automatic test_port_lookup();
    make_packet(0, 1, 8'd6, 32'h0a00_0001, 8'h00, 8'h01);   // No source
    make_packet(1, 1, 8'd6, 32'h0a00_0001, 8'h02, 8'h01);   // CPU port
    make_packet(2, 1, 8'd6, 32'h0a00_0001, 8'h04, 8'h08);   // MAC port
    fork
      send_beats(3);
      collect_beats(3);
    join
    compare_rx(3);
    finish_test("port lookup");
  endtask

  task automatic test_back_pressure();
    int accepted;
    int waited;
    accepted = 0;
    waited   = 0;
    clear_counters();
    make_packet(0, 6, 8'd1, 32'h0a00_0002, 8'h10, 8'h20);
    fork
      send_beats(6);
      begin
        @(negedge axis_aclk);
        while (s_axis_tready && waited < wait_limit) begin
          if (s_axis_tvalid)
            accepted++;
          @(negedge axis_aclk);
          waited++;
        end
        if (s_axis_tready)
          report_timeout("s_axis_tready to fall");
        check_value("accepted beats", 3, accepted);
        check_value("m_axis_tvalid", 1, m_axis_tvalid);
        repeat (4) @(negedge axis_aclk);   // Stall holds
        check_value("s_axis_tready", 0, s_axis_tready);
        collect_beats(6);
      end
    join
    compare_rx(6);
    apb_read_check(`OPL_REG_ICMPOUT, "icmpout", 1);   // Stalled header counts once
    finish_test("back-pressure");
  endtask

  task automatic test_counters();
    clear_counters();
    make_packet(0, 2, 8'd1, 32'h0a00_0003, 8'h08, 8'h04);
    make_packet(2, 1, 8'd1, 32'h0a00_0004, 8'h01, 8'h02);
    make_packet(3, 3, 8'd17, 32'h0a00_0003, 8'h40, 8'h80);
    fork
      send_beats(6);
      collect_beats(6);
    join
    compare_rx(6);
    apb_read_check(`OPL_REG_PKTIN, "pktin", 3);
    apb_read_check(`OPL_REG_PKTOUT, "pktout", 3);
    apb_read_check(`OPL_REG_ICMPOUT, "icmpout", 2);
    apb_read_check(`OPL_REG_PKTIN, "pktin", 0);   // Cleared by the read
    apb_read_check(`OPL_REG_PKTOUT, "pktout", 0);
    apb_read_check(`OPL_REG_ICMPOUT, "icmpout", 0);
    finish_test("counters");
  endtask

  task automatic test_target_ip();
    opl_pkg::ipv4_addr_t tgt;
    tgt = 32'hc0a8_0105;
    apb_write(`OPL_REG_TGTIP, tgt);
    apb_read_check(`OPL_REG_TGTIP, "tgt_ip", tgt);
    clear_counters();
    make_packet(0, 1, 8'd6, tgt, 8'h04, 8'h08);
    make_packet(1, 2, 8'd17, 32'hc0a8_0106, 8'h04, 8'h08);
    make_packet(3, 1, 8'd1, tgt, 8'h20, 8'h10);
    fork
      send_beats(4);
      collect_beats(4);
    join
    compare_rx(4);
    apb_read_check(`OPL_REG_TGTIPOUT, "tgtipout", 2);
    // More traffic so every counter is nonzero
    make_packet(0, 1, 8'd1, tgt, 8'h02, 8'h01);
    make_packet(1, 1, 8'd6, 32'h0a01_0203, 8'h00, 8'h01);
    fork
      send_beats(2);
      collect_beats(2);
    join
    apb_write(`OPL_REG_RESET, 32'd1 << `OPL_RST_CLR_CNT_BIT);
    apb_read_check(`OPL_REG_PKTIN, "pktin", 0);
    apb_read_check(`OPL_REG_PKTOUT, "pktout", 0);
    apb_read_check(`OPL_REG_ICMPOUT, "icmpout", 0);
    apb_read_check(`OPL_REG_TGTIPOUT, "tgtipout", 0);
    apb_read_check(`OPL_REG_TGTIP, "tgt_ip", tgt);   // Kept
    apb_write(`OPL_REG_RESET, 32'd1 << `OPL_RST_CLR_REGS_BIT);
    apb_read_check(`OPL_REG_TGTIP, "tgt_ip", 0);
    finish_test("target IP");
  endtask

  initial begin
    axis_resetn   = 1'b0;
    s_axis_tdata  = '0;
    s_axis_tkeep  = '0;
    s_axis_tuser  = '0;
    s_axis_tvalid = 1'b0;
    s_axis_tlast  = 1'b0;
    m_axis_tready = 1'b0;
    apb_req       = '0;
    rx_cnt        = 0;
    test_errs     = 0;
    tests_ok      = 0;
    tests_bad     = 0;
    void'($urandom(32'hfbcf4a92));
    repeat (8) @(posedge axis_aclk);
    axis_resetn <= 1'b1;
    test_reset_state();
    test_port_lookup();
    test_back_pressure();
    test_counters();
    test_target_ip();
    $display("Tests passed: %0d, tests failed: %0d", tests_ok, tests_bad);
    if (tests_bad == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// File: compile.f
+incdir+rtl
rtl/opl_pkg.sv
rtl/opl_pkt_fifo.sv
rtl/opl_header_decode.sv
rtl/opl_port_select.sv
rtl/opl_stats_counters.sv
rtl/opl_apb_regs.sv
rtl/nic_output_port_lookup.sv
testbench/tb_nic_output_port_lookup.sv
